/* rtl/conv_cfg_pkg.sv */
`default_nettype none

package conv_cfg_pkg;

  localparam int MAX_WIDTH = 64;
  localparam int MAX_HEIGHT = 64;
  localparam int KERNEL_ROWS = 3;
  localparam int PIXELS_PER_WORD = 4;
  localparam int ROW_WORDS_MAX = MAX_WIDTH / PIXELS_PER_WORD;

  // derived field widths
  localparam int WIDTH_BITS = $clog2(MAX_WIDTH + 1);
  localparam int HEIGHT_BITS = $clog2(MAX_HEIGHT + 1);
  localparam int WORD_INDEX_BITS = $clog2(ROW_WORDS_MAX);
  localparam int POS_BITS = $clog2(MAX_WIDTH);

  typedef struct packed {
    logic                   spare;
    logic [WIDTH_BITS-1:0]  width;
    logic [HEIGHT_BITS-1:0] height;
    logic [1:0]             stride;
    logic [15:0]            base;
  } layer_cfg_t;

  typedef enum logic [3:0] {
    CTRL = 4'h0,
    GEOM = 4'h4,
    BASE = 4'h8
  } reg_addr_e;

endpackage

`default_nettype wire

/* rtl/conv_mem_pkg.sv */
`default_nettype none

package conv_mem_pkg;

  import conv_cfg_pkg::*;

  // raw view for storage, lane view for pixel select
  typedef union packed {
    logic [31:0]                      raw;
    logic [PIXELS_PER_WORD-1:0][7:0]  lane;
  } mem_word_u;

  typedef struct packed {
    logic [15:0] addr;
  } mem_req_t;

  typedef struct packed {
    mem_word_u data;
  } mem_rsp_t;

  typedef struct packed {
    logic                       en;
    logic [WORD_INDEX_BITS-1:0] index;
    mem_word_u                  data;
  } buf_wr_t;

  typedef struct packed {
    logic [7:0]          top;
    logic [7:0]          middle;
    logic [7:0]          bottom;
    logic [POS_BITS-1:0] row;
    logic [POS_BITS-1:0] x;
  } window_col_t;

endpackage

`default_nettype wire

/* rtl/conv_load_regs.sv */
`default_nettype none

module conv_load_regs
  import conv_cfg_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic [3:0]  paddr,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [31:0] pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             pslverr,
  output layer_cfg_t       cfg,
  output logic             start_pulse,
  input  wire logic        frame_done
);

  reg_addr_e addr;
  logic      access;
  logic      mapped;
  logic      busy_err;
  logic      wr_ok;
  logic      busy;
  logic      done;

  assign addr = reg_addr_e'(paddr);
  assign access = psel && penable;
  assign mapped = (addr == CTRL) || (addr == GEOM) || (addr == BASE);
  // reprogram or restart during a frame
  assign busy_err = pwrite && busy && ((addr != CTRL) || pwdata[0]);
  assign pslverr = access && (!mapped || busy_err);
  assign pready = 1'b1;
  assign wr_ok = access && pwrite && !pslverr;
  assign start_pulse = wr_ok && (addr == CTRL) && pwdata[0];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg <= '0;
      busy <= 1'b0;
      done <= 1'b0;
    end
    else
    begin
      if (wr_ok && (addr == GEOM))
      begin
        cfg.width <= pwdata[6:0];
        cfg.height <= pwdata[14:8];
        cfg.stride <= pwdata[17:16];
      end
      if (wr_ok && (addr == BASE))
        cfg.base <= pwdata[15:0];
      if (start_pulse)
      begin
        busy <= 1'b1;
        done <= 1'b0;
      end
      else if (frame_done)
      begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_comb
  begin
    case (addr)
      CTRL:    prdata = {30'b0, done, busy};
      GEOM:    prdata = {14'b0, cfg.stride, 1'b0, cfg.height, 1'b0, cfg.width};
      BASE:    prdata = {16'b0, cfg.base};
      default: prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/conv_load_addr_gen.sv */
`default_nettype none

module conv_load_addr_gen
  import conv_cfg_pkg::*, conv_mem_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          reset,
  input  wire layer_cfg_t    cfg,
  input  wire logic          start_pulse,
  input  wire logic          tile_drained,
  output logic               mem_req_valid,
  input  wire logic          mem_req_ready,
  output mem_req_t           mem_req,
  output logic [POS_BITS-1:0] tile_row,
  output logic               frame_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_e;

  state_e                     state;
  logic [WORD_INDEX_BITS-1:0] word_idx;
  logic [1:0]                 row_sel;
  logic [4:0]                 words;
  logic [7:0]                 next_top;
  logic [15:0]                row_addr;
  logic                       last_word;
  logic                       last_tile;
  logic                       req_fire;

  assign words = cfg.width[WIDTH_BITS-1:2];
  assign last_word = ({1'b0, word_idx} == (words - 5'd1));
  // next tile would run past the bottom row
  assign next_top = 8'(tile_row) + 8'(cfg.stride) + 8'd2;
  assign last_tile = next_top >= 8'(cfg.height);

  assign row_addr = 16'(tile_row) + 16'(row_sel);
  assign mem_req.addr = cfg.base + row_addr * 16'(words) + 16'(word_idx);
  assign mem_req_valid = (state == ST_REQ);
  assign req_fire = mem_req_valid && mem_req_ready;
  assign frame_done = (state == ST_WAIT) && tile_drained && last_tile;

  //////////////////////////////
  // tile / row / word loop nest
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
      word_idx <= '0;
      row_sel <= '0;
      tile_row <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (start_pulse)
          begin
            word_idx <= '0;
            row_sel <= '0;
            tile_row <= '0;
            state <= ST_REQ;
          end
        ST_REQ:
          if (req_fire)
          begin
            if (last_word)
            begin
              word_idx <= '0;
              if (row_sel == 2'(KERNEL_ROWS - 1))
              begin
                row_sel <= '0;
                state <= ST_WAIT;
              end
              else
                row_sel <= row_sel + 2'd1;
            end
            else
              word_idx <= word_idx + 1'b1;
          end
        ST_WAIT:
          if (tile_drained)
          begin
            if (last_tile)
              state <= ST_IDLE;
            else
            begin
              tile_row <= tile_row + POS_BITS'(cfg.stride);
              state <= ST_REQ;
            end
          end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/conv_row_dispatch.sv */
`default_nettype none

module conv_row_dispatch
  import conv_cfg_pkg::*, conv_mem_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire layer_cfg_t cfg,
  input  wire logic       mem_rsp_valid,
  input  wire mem_rsp_t   mem_rsp,
  output buf_wr_t         buf_wr [KERNEL_ROWS],
  output logic            tile_loaded
);

  logic [WORD_INDEX_BITS-1:0] word_idx;
  logic [1:0]                 buf_idx;
  logic [4:0]                 words;
  logic                       last_word;
  logic                       last_q;
  logic [KERNEL_ROWS-1:0]     wr_en;
  logic [WORD_INDEX_BITS-1:0] wr_index;
  mem_word_u                  wr_data;

  assign words = cfg.width[WIDTH_BITS-1:2];
  assign last_word = ({1'b0, word_idx} == (words - 5'd1));

  // responses arrive in request order, so counters track position
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      word_idx <= '0;
      buf_idx <= '0;
      wr_en <= '0;
      last_q <= 1'b0;
      tile_loaded <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < KERNEL_ROWS; i++)
        wr_en[i] <= mem_rsp_valid && (buf_idx == 2'(i));
      last_q <= mem_rsp_valid && last_word && (buf_idx == 2'(KERNEL_ROWS - 1));
      tile_loaded <= last_q;
      if (mem_rsp_valid)
      begin
        if (last_word)
        begin
          word_idx <= '0;
          buf_idx <= (buf_idx == 2'(KERNEL_ROWS - 1)) ? 2'd0 : buf_idx + 2'd1;
        end
        else
          word_idx <= word_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    wr_index <= word_idx;
    wr_data <= mem_rsp.data;
  end

  always_comb
  begin
    for (int i = 0; i < KERNEL_ROWS; i++)
      buf_wr[i] = '{en: wr_en[i], index: wr_index, data: wr_data};
  end

endmodule

`default_nettype wire

/* rtl/conv_row_buffer.sv */
`default_nettype none

module conv_row_buffer
  import conv_cfg_pkg::*, conv_mem_pkg::*;
(
  input  wire logic                       clk,
  input  wire buf_wr_t                    wr,
  input  wire logic [WORD_INDEX_BITS-1:0] rd_index,
  output mem_word_u                       rd_data
);

  // one map row, four pixels per word
  mem_word_u mem [ROW_WORDS_MAX];

  always_ff @(posedge clk)
  begin
    if (wr.en)
      mem[wr.index] <= wr.data;
    rd_data <= mem[rd_index];
  end

endmodule

`default_nettype wire

/* rtl/conv_window_reader.sv */
`default_nettype none

module conv_window_reader
  import conv_cfg_pkg::*, conv_mem_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire layer_cfg_t                 cfg,
  input  wire logic [POS_BITS-1:0]        tile_row,
  input  wire logic                       tile_loaded,
  output logic [WORD_INDEX_BITS-1:0]      rd_index,
  input  wire mem_word_u                  rd_data [KERNEL_ROWS],
  output logic                            win_valid,
  input  wire logic                       win_ready,
  output window_col_t                     win,
  output logic                            tile_drained
);

  typedef enum logic {
    ST_IDLE,
    ST_SHOW
  } state_e;

  state_e              state;
  logic [POS_BITS-1:0] x;
  logic [POS_BITS:0]   x_next;
  logic [POS_BITS-1:0] rd_x;
  logic                accept;
  logic                last_col;

  assign x_next = {1'b0, x} + (POS_BITS + 1)'(cfg.stride);
  assign last_col = x_next >= cfg.width;
  assign win_valid = (state == ST_SHOW);
  assign accept = win_valid && win_ready;
  assign tile_drained = accept && last_col;

  // read one column ahead on accept, hold the index otherwise
  assign rd_x = (accept && !last_col) ? x_next[POS_BITS-1:0] : x;
  assign rd_index = rd_x[POS_BITS-1:2];

  always_comb
  begin
    win.top = rd_data[0].lane[x[1:0]];
    win.middle = rd_data[1].lane[x[1:0]];
    win.bottom = rd_data[2].lane[x[1:0]];
    win.row = tile_row;
    win.x = x;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
      x <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (tile_loaded)
            state <= ST_SHOW;
        ST_SHOW:
          if (accept)
          begin
            if (last_col)
            begin
              state <= ST_IDLE;
              x <= '0;
            end
            else
              x <= x_next[POS_BITS-1:0];
          end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/conv_load_top.sv */
`default_nettype none

module conv_load_top
  import conv_cfg_pkg::*, conv_mem_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  // APB
  input  wire logic [3:0]  paddr,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [31:0] pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             pslverr,
  // external memory
  output logic             mem_req_valid,
  input  wire logic        mem_req_ready,
  output mem_req_t         mem_req,
  input  wire logic        mem_rsp_valid,
  input  wire mem_rsp_t    mem_rsp,
  // window stream
  output logic             win_valid,
  input  wire logic        win_ready,
  output window_col_t      win
);

  layer_cfg_t                 cfg;
  logic                       start_pulse;
  logic                       frame_done;
  logic                       tile_loaded;
  logic                       tile_drained;
  logic [POS_BITS-1:0]        tile_row;
  buf_wr_t                    buf_wr [KERNEL_ROWS];
  logic [WORD_INDEX_BITS-1:0] rd_index;
  mem_word_u                  rd_data [KERNEL_ROWS];

  conv_load_regs u_regs (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .cfg(cfg), .start_pulse(start_pulse), .frame_done(frame_done)
  );

  conv_load_addr_gen u_addr_gen (
    .clk(clk), .reset(reset), .cfg(cfg), .start_pulse(start_pulse),
    .tile_drained(tile_drained), .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready), .mem_req(mem_req),
    .tile_row(tile_row), .frame_done(frame_done)
  );

  conv_row_dispatch u_dispatch (
    .clk(clk), .reset(reset), .cfg(cfg), .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp(mem_rsp), .buf_wr(buf_wr), .tile_loaded(tile_loaded)
  );

  for (genvar i = 0; i < KERNEL_ROWS; i++)
  begin : g_row_buf
    conv_row_buffer u_buf (
      .clk(clk), .wr(buf_wr[i]), .rd_index(rd_index), .rd_data(rd_data[i])
    );
  end

  conv_window_reader u_reader (
    .clk(clk), .reset(reset), .cfg(cfg), .tile_row(tile_row),
    .tile_loaded(tile_loaded), .rd_index(rd_index), .rd_data(rd_data),
    .win_valid(win_valid), .win_ready(win_ready), .win(win),
    .tile_drained(tile_drained)
  );

endmodule

`default_nettype wire

/* verification/conv_load_assertions.sv */
`default_nettype none

module conv_load_assertions
  import conv_mem_pkg::*;
(
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        mem_req_valid,
  input wire logic        mem_req_ready,
  input wire mem_req_t    mem_req,
  input wire logic        win_valid,
  input wire logic        win_ready,
  input wire window_col_t win
);

  timeunit 1ns;
  timeprecision 1ps;

  // a stalled request keeps its address
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else $error("memory request dropped or changed before ready");

  a_win_hold: assert property (@(posedge clk) disable iff (reset)
    win_valid && !win_ready |=> win_valid && $stable(win))
    else $error("window column dropped or changed before ready");

  // both streams quiet right after reset
  a_reset_quiet: assert property (@(posedge clk) reset |=> !mem_req_valid && !win_valid)
    else $error("valid raised in the cycle after reset");

endmodule

bind conv_load_top conv_load_assertions u_assertions (
  .clk(clk), .reset(reset), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
  .mem_req(mem_req), .win_valid(win_valid), .win_ready(win_ready), .win(win)
);

`default_nettype wire

/* verification/conv_load_tb.sv */
`default_nettype none

module conv_load_tb
  import conv_cfg_pkg::*, conv_mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum {
    MEM_RANDOM,
    MEM_FAST,
    WIN_STALL,
    BUSY_ERRORS
  } frame_mode_e;

  localparam int FRAMES = 10;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic [3:0]  paddr = '0;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [31:0] pwdata = '0;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        mem_req_valid;
  logic        mem_req_ready = 1'b0;
  mem_req_t    mem_req;
  logic        mem_rsp_valid = 1'b0;
  mem_rsp_t    mem_rsp = '0;
  logic        win_valid;
  logic        win_ready = 1'b0;
  window_col_t win;

  mem_req_t    exp_req [$];
  window_col_t exp_win [$];
  logic [15:0] pend_addr [$];
  longint      pend_due [$];
  longint      cycle = 0;
  longint      last_due = 0;
  longint      cycle_limit = 0;
  bit          mem_fast = 1'b0;
  bit          backpressure = 1'b0;
  int          stall_left = 0;
  layer_cfg_t  frames [FRAMES];
  frame_mode_e modes [FRAMES];

  conv_load_top uut (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
    .win_valid(win_valid), .win_ready(win_ready), .win(win)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic logic [31:0] word_hash(logic [15:0] addr);
    return {addr ^ 16'h5a3c, addr * 16'h9e37} ^ (32'(addr) * 32'h0101_0101);
  endfunction

  function automatic window_col_t expected_window(layer_cfg_t c, int row, int x);
    window_col_t w;
    logic [7:0]  px [KERNEL_ROWS];
    logic [15:0] addr;
    for (int r = 0; r < KERNEL_ROWS; r++)
    begin
      addr = c.base + 16'((row + r) * (int'(c.width) / 4) + x / 4);
      px[r] = 8'(word_hash(addr) >> (8 * (x % 4)));
    end
    w.top = px[0];
    w.middle = px[1];
    w.bottom = px[2];
    w.row = 6'(row);
    w.x = 6'(x);
    return w;
  endfunction

  function automatic logic [31:0] geom_word(layer_cfg_t c);
    return 32'(c.width) | (32'(c.height) << 8) | (32'(c.stride) << 16);
  endfunction

  function automatic longint frame_cycles(layer_cfg_t c);
    int tiles;
    tiles = (int'(c.height) - 3) / int'(c.stride) + 1;
    return longint'(tiles) * longint'(3 * int'(c.width) / 4) * 20;
  endfunction

  // tiles step by stride, rows top to bottom, words left to right
  task automatic load_expected(layer_cfg_t c);
    int       words;
    mem_req_t q;
    words = int'(c.width) / 4;
    for (int t = 0; t + 2 < int'(c.height); t += int'(c.stride))
    begin
      for (int r = 0; r < KERNEL_ROWS; r++)
        for (int i = 0; i < words; i++)
        begin
          q.addr = c.base + 16'((t + r) * words + i);
          exp_req.push_back(q);
        end
      for (int x = 0; x < int'(c.width); x += int'(c.stride))
        exp_win.push_back(expected_window(c, t, x));
    end
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////
  task automatic fail_now(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_window(string name, window_col_t expv, window_col_t act);
    if (act !== expv)
      fail_now($sformatf("Fail %0t %s expected row %0d x %0d px %h actual row %0d x %0d px %h",
        $time, name, expv.row, expv.x, {expv.top, expv.middle, expv.bottom},
        act.row, act.x, {act.top, act.middle, act.bottom}));
  endtask

  task automatic check_req(string name, mem_req_t expv, mem_req_t act);
    if (act !== expv)
      fail_now($sformatf("Fail %0t %s expected %h actual %h", $time, name, expv.addr, act.addr));
  endtask

  task automatic check_reg(string name, logic [31:0] expv, logic [31:0] act);
    if (act !== expv)
      fail_now($sformatf("Fail %0t %s expected %h actual %h", $time, name, expv, act));
  endtask

  task automatic check_flag(string name, logic expv, logic act);
    if (act !== expv)
      fail_now($sformatf("Fail %0t %s expected %b actual %b", $time, name, expv, act));
  endtask

  //////////////////////////////
  // APB driver
  //////////////////////////////
  task automatic apb_access(input logic [3:0] addr, input logic write, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #1;
    paddr = addr;
    pwrite = write;
    pwdata = data;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    check_flag("pready", 1'b1, pready);
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_write(logic [3:0] addr, logic [31:0] data, logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    check_flag("pslverr", exp_err, err);
  endtask

  task automatic reg_read_check(logic [3:0] addr, logic [31:0] expv, logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, 32'h0, rdata, err);
    check_flag("pslverr", exp_err, err);
    if (!exp_err)
      check_reg("prdata", expv, rdata);
  endtask

  task automatic run_frame(layer_cfg_t c, frame_mode_e mode);
    mem_fast = (mode == MEM_FAST);
    backpressure = (mode == WIN_STALL);
    reg_write(GEOM, geom_word(c), 1'b0);
    reg_write(BASE, 32'(c.base), 1'b0);
    load_expected(c);
    reg_write(CTRL, 32'h1, 1'b0);
    if (mode == BUSY_ERRORS)
    begin
      reg_write(CTRL, 32'h1, 1'b1);
      reg_write(GEOM, geom_word(frames[0]), 1'b1);
      reg_write(BASE, 32'(~c.base), 1'b1);
      reg_read_check(4'hC, 32'h0, 1'b1);
      reg_read_check(CTRL, 32'h1, 1'b0);
    end
    while (exp_win.size() != 0)
      @(posedge clk);
    reg_read_check(CTRL, 32'h2, 1'b0);
    reg_read_check(GEOM, geom_word(c), 1'b0);
    if (exp_req.size() != 0 || pend_addr.size() != 0)
      fail_now("frame finished with memory requests still outstanding");
  endtask

  // memory model and window sink, driven just after the edge
  always @(posedge clk)
  begin
    cycle = cycle + 1;
    #1;
    mem_req_ready = mem_fast || ($urandom_range(0, 3) != 0);
    if (pend_due.size() != 0 && pend_due[0] <= cycle)
    begin
      mem_rsp_valid = 1'b1;
      mem_rsp.data.raw = word_hash(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    else
      mem_rsp_valid = 1'b0;
    if (stall_left > 0)
      stall_left = stall_left - 1;
    else if (backpressure)
    begin
      win_ready = !win_ready;
      stall_left = win_ready ? $urandom_range(0, 4) : $urandom_range(5, 30);
    end
    else
      win_ready = mem_fast || ($urandom_range(0, 3) != 0);
  end

  // compare process, sampled mid-cycle
  always @(negedge clk)
  begin
    int     delay;
    longint due;
    if (!reset && mem_req_valid && exp_req.size() == 0)
      fail_now("memory request issued when none was expected");
    else if (!reset && mem_req_valid && mem_req_ready)
    begin
      check_req("mem_req", exp_req.pop_front(), mem_req);
      delay = mem_fast ? 1 : $urandom_range(1, 6);
      due = cycle + longint'(delay);
      if (due <= last_due)
        due = last_due + 1;
      last_due = due;
      pend_addr.push_back(mem_req.addr);
      pend_due.push_back(due);
    end
    if (!reset && win_valid && exp_win.size() == 0)
      fail_now("window column presented when none was expected");
    else if (!reset && win_valid && win_ready)
      check_window("win", exp_win.pop_front(), win);
  end

  initial
  begin
    wait (cycle_limit != 0);
    repeat (cycle_limit) @(posedge clk);
    fail_now("run timed out before all frames finished");
  end

  initial
  begin
    longint limit;
    void'($urandom(32'ha8c7_7850));
    frames[0] = '{spare: 1'b0, width: 7'd16, height: 7'd3, stride: 2'd1, base: 16'h0100};
    modes[0] = MEM_FAST;
    for (int i = 1; i < FRAMES - 1; i++)
    begin
      frames[i].spare = 1'b0;
      frames[i].width = 7'(4 * $urandom_range(1, 16));
      frames[i].height = 7'($urandom_range(3, 20));
      frames[i].stride = 2'(i % 3 + 1);
      frames[i].base = 16'($urandom);
      modes[i] = (i >= 7) ? WIN_STALL : MEM_RANDOM;
    end
    // base near the top of the address space
    frames[FRAMES-1] = '{spare: 1'b0, width: 7'd32, height: 7'd10, stride: 2'd2, base: 16'hffe0};
    modes[FRAMES-1] = BUSY_ERRORS;
    limit = 0;
    for (int i = 0; i < FRAMES; i++)
      limit = limit + frame_cycles(frames[i]);
    cycle_limit = limit + 2000;

    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    reg_read_check(CTRL, 32'h0, 1'b0);
    repeat (20) @(posedge clk);
    reg_write(GEOM, geom_word(frames[0]), 1'b0);
    reg_write(BASE, 32'(frames[0].base), 1'b0);
    reg_read_check(GEOM, geom_word(frames[0]), 1'b0);
    reg_read_check(BASE, 32'(frames[0].base), 1'b0);

    for (int i = 0; i < FRAMES; i++)
      run_frame(frames[i], modes[i]);
    reg_read_check(BASE, 32'(frames[FRAMES-1].base), 1'b0);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/conv_cfg_pkg.sv
rtl/conv_mem_pkg.sv
rtl/conv_load_regs.sv
rtl/conv_load_addr_gen.sv
rtl/conv_row_dispatch.sv
rtl/conv_row_buffer.sv
rtl/conv_window_reader.sv
rtl/conv_load_top.sv
verification/conv_load_assertions.sv
verification/conv_load_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module conv_load_tb -f sources.f -o conv_load_sim
./obj_dir/conv_load_sim > sim.log 2>&1 || true
cat sim.log
if grep -q '>>> FAIL' sim.log; then
  exit 1
fi
grep -q '>>> PASS' sim.log
